/* hdl/imul_collect.sv */
// round-robin drain of finished lanes into one registered response port
// lanes are visited in issue order, so responses leave in request order

`timescale 1ns/10ps
`default_nettype none

module imul_collect (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [imul_pkg::num_lanes-1:0] lane_done,
  input  imul_pkg::mul_resp_t            lane_product [imul_pkg::num_lanes],
  output logic [imul_pkg::num_lanes-1:0] lane_take,
  output imul_pkg::mul_resp_t            resp,
  output logic                           resp_val,
  input  logic                           resp_rdy
);

  // lane whose result goes out next
  logic [imul_pkg::lane_idx_w-1:0] drain_ptr;

  // output stage empty, or emptied on this edge
  logic                            stage_free;
  logic                            load;

  // --------------------------------------------------------------------------
  // load decision
  // --------------------------------------------------------------------------

  assign stage_free = !resp_val || resp_rdy;
  assign load       = lane_done[drain_ptr] && stage_free;

  // take releases the lane on the same edge the product is copied
  always_comb begin
    lane_take = '0;
    if (load) begin
      lane_take[drain_ptr] = 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // drain pointer and response register
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      drain_ptr <= '0;
    end else if (load) begin
      if (drain_ptr == imul_pkg::lane_idx_w'(imul_pkg::num_lanes - 1)) begin
        drain_ptr <= '0;
      end else begin
        drain_ptr <= drain_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (load) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  // payload holds while stalled
  always_ff @(posedge clk) begin
    if (load) begin
      resp <= lane_product[drain_ptr];
    end
  end

endmodule

`default_nettype wire

/* hdl/imul_dispatch.sv */
// round-robin issue of requests to the lanes
// ready follows only the lane at the issue pointer, so issue order is drain order

`timescale 1ns/10ps
`default_nettype none

module imul_dispatch (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_val,
  output logic                          req_rdy,
  input  logic [imul_pkg::num_lanes-1:0] lane_idle,
  output logic [imul_pkg::num_lanes-1:0] lane_start
);

  // next lane to receive a request
  logic [imul_pkg::lane_idx_w-1:0] issue_ptr;
  logic                            xfer;

  // --------------------------------------------------------------------------
  // handshake and start decode
  // --------------------------------------------------------------------------

  // a busy lane at the pointer blocks issue even if others are idle
  assign req_rdy = lane_idle[issue_ptr];
  assign xfer    = req_val && req_rdy;

  // one-hot start strobe for the lane at the pointer
  always_comb begin
    lane_start = '0;
    if (xfer) begin
      lane_start[issue_ptr] = 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // issue pointer
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      issue_ptr <= '0;
    end else if (xfer) begin
      if (issue_ptr == imul_pkg::lane_idx_w'(imul_pkg::num_lanes - 1)) begin
        issue_ptr <= '0;
      end else begin
        issue_ptr <= issue_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/imul_iter_lane.sv */
// one iterative shift-and-add lane, signed 32x32 -> 64
// started by a one-cycle start pulse, released by a one-cycle take pulse

`timescale 1ns/10ps
`default_nettype none

module imul_iter_lane (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  imul_pkg::mul_req_t  req,
  input  logic                take,
  output logic                idle,
  output logic                done,
  output imul_pkg::mul_resp_t product
);

  // --------------------------------------------------------------------------
  // declarations
  // --------------------------------------------------------------------------

  imul_pkg::lane_state_t state;
  imul_pkg::lane_state_t state_next;

  // operand magnitudes seen on the broadcast request
  logic [imul_pkg::op_w-1:0]   mag_a;
  logic [imul_pkg::op_w-1:0]   mag_b;

  // shifting multiplicand, widened to the product width
  logic [imul_pkg::prod_w-1:0] mcand;
  // multiplier, shifts right, bit 0 picks the add
  logic [imul_pkg::op_w-1:0]   mplier;
  // running unsigned partial product
  logic [imul_pkg::prod_w-1:0] acc;
  logic [imul_pkg::step_w-1:0] cnt;

  // operand signs captured at start
  logic                        sign_a;
  logic                        sign_b;
  logic                        neg;

  // high once the last add has been applied
  logic                        last_step;
  logic                        step_en;

  // --------------------------------------------------------------------------
  // sign removal
  // --------------------------------------------------------------------------

  // two's complement magnitude, most negative value maps to 2^31 unsigned
  assign mag_a = req.a[imul_pkg::op_w-1] ? (~req.a + 1'b1) : req.a;
  assign mag_b = req.b[imul_pkg::op_w-1] ? (~req.b + 1'b1) : req.b;

  // --------------------------------------------------------------------------
  // control FSM
  // --------------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      imul_pkg::lane_idle: begin
        if (start) begin
          state_next = imul_pkg::lane_calc;
        end
      end
      imul_pkg::lane_calc: begin
        // leave one cycle after the counter hit zero
        if (last_step) begin
          state_next = imul_pkg::lane_done;
        end
      end
      imul_pkg::lane_done: begin
        // collector has copied the product
        if (take) begin
          state_next = imul_pkg::lane_idle;
        end
      end
      default: begin
        state_next = imul_pkg::lane_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imul_pkg::lane_idle;
    end else begin
      state <= state_next;
    end
  end

  // steps run only until the final add, then the lane settles one cycle
  assign step_en = (state == imul_pkg::lane_calc) && !last_step;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_step <= 1'b0;
    end else if (start) begin
      last_step <= 1'b0;
    end else if (step_en && (cnt == '0)) begin
      last_step <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // shift/add datapath
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (start) begin
      mcand  <= {{(imul_pkg::prod_w - imul_pkg::op_w){1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
      cnt    <= imul_pkg::step_w'(imul_pkg::op_w - 1);
      sign_a <= req.a[imul_pkg::op_w-1];
      sign_b <= req.b[imul_pkg::op_w-1];
    end else if (step_en) begin
      // add the shifted multiplicand when the current multiplier bit is set
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
      // wraps after the last step, unused from then on
      cnt    <= cnt - 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // outputs
  // --------------------------------------------------------------------------

  // product is negative when exactly one operand was
  assign neg = sign_a ^ sign_b;

  assign product.product = neg ? (~acc + 1'b1) : acc;

  assign idle = (state == imul_pkg::lane_idle);
  assign done = (state == imul_pkg::lane_done);

endmodule

`default_nettype wire

/* hdl/imul_pkg.sv */
// shared widths, lane count and message types for the signed multiplier
// every RTL file and the testbench refer to these by scoped names

`default_nettype none

package imul_pkg;

  // --------------------------------------------------------------------------
  // sizing
  // --------------------------------------------------------------------------

  // number of identical iterative lanes
  localparam int num_lanes  = 4;
  // lane pointer width, num_lanes is a power of two
  localparam int lane_idx_w = 2;

  // operand and product widths
  localparam int op_w   = 32;
  localparam int prod_w = 64;

  // step counter runs op_w-1 down to zero
  localparam int step_w = 5;

  // --------------------------------------------------------------------------
  // messages
  // --------------------------------------------------------------------------

  // request: two signed operands, a in the upper word
  typedef struct packed {
    logic [op_w-1:0] a;
    logic [op_w-1:0] b;
  } mul_req_t;

  // response: full signed product
  typedef struct packed {
    logic [prod_w-1:0] product;
  } mul_resp_t;

  // lane control states
  typedef enum logic [1:0] {
    lane_idle = 2'd0,
    lane_calc = 2'd1,
    lane_done = 2'd2
  } lane_state_t;

endpackage

`default_nettype wire

/* hdl/imul_top.sv */
// signed 32x32 -> 64 multiplier built from round-robin iterative lanes
// valid/ready on both the request and the response side

`timescale 1ns/10ps
`default_nettype none

module imul_top (
  input  logic                clk,
  input  logic                reset,
  input  imul_pkg::mul_req_t  req,
  input  logic                req_val,
  output logic                req_rdy,
  output imul_pkg::mul_resp_t resp,
  output logic                resp_val,
  input  logic                resp_rdy
);

  // per-lane status and strobes
  logic [imul_pkg::num_lanes-1:0] lane_idle;
  logic [imul_pkg::num_lanes-1:0] lane_start;
  logic [imul_pkg::num_lanes-1:0] lane_done;
  logic [imul_pkg::num_lanes-1:0] lane_take;
  imul_pkg::mul_resp_t            lane_product [imul_pkg::num_lanes];

  imul_dispatch u_dispatch (
    .clk        (clk),
    .reset      (reset),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .lane_idle  (lane_idle),
    .lane_start (lane_start)
  );

  // request is broadcast, only the started lane captures it
  for (genvar i = 0; i < imul_pkg::num_lanes; i++) begin : g_lane
    imul_iter_lane u_lane (
      .clk     (clk),
      .reset   (reset),
      .start   (lane_start[i]),
      .req     (req),
      .take    (lane_take[i]),
      .idle    (lane_idle[i]),
      .done    (lane_done[i]),
      .product (lane_product[i])
    );
  end

  imul_collect u_collect (
    .clk          (clk),
    .reset        (reset),
    .lane_done    (lane_done),
    .lane_product (lane_product),
    .lane_take    (lane_take),
    .resp         (resp),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the multiplier testbench with Verilator, result taken from sim.log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module imul_tb -o imul_sim
./obj_dir/imul_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
grep -q "TEST PASS" sim.log

/* sim.f */
hdl/imul_pkg.sv
hdl/imul_iter_lane.sv
hdl/imul_dispatch.sv
hdl/imul_collect.sv
hdl/imul_top.sv
testbench/imul_tb_assert.sv
testbench/imul_tb.sv

/* testbench/imul_tb.sv */
// testbench for imul_top with corner, latency, ordering, stall and random traffic
// expected products come from a signed 64-bit model kept in a queue

`timescale 1ns/10ps
`default_nettype none

module imul_tb;

  logic                clk;
  logic                reset;
  imul_pkg::mul_req_t  req;
  logic                req_val;
  logic                req_rdy;
  imul_pkg::mul_resp_t resp;
  logic                resp_val;
  logic                resp_rdy;

  int    seed       = 32'h587c;
  // second stream for response stalls
  int    stall_seed = ~32'h587c;
  // 0 always ready, 1 always stalled, 2 random stalls
  int    stall_mode = 0;
  // new random ready value every falling edge
  logic  stall_draw;
  int    wait_limit = 400;
  string test_name  = "reset";
  int    mismatch_count = 0;
  int    other_count    = 0;
  logic [imul_pkg::prod_w-1:0] expect_q [$];

  imul_top u_dut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // model: both operands sign extended, low product_w bits kept
  function automatic logic [imul_pkg::prod_w-1:0] signed_product(
    input logic [imul_pkg::op_w-1:0] a,
    input logic [imul_pkg::op_w-1:0] b
  );
    logic [imul_pkg::prod_w-1:0] wide_a;
    logic [imul_pkg::prod_w-1:0] wide_b;
    wide_a = {{imul_pkg::op_w{a[imul_pkg::op_w-1]}}, a};
    wide_b = {{imul_pkg::op_w{b[imul_pkg::op_w-1]}}, b};
    return wide_a * wide_b;
  endfunction

  initial begin : stall_source
    stall_draw = 1'b1;
    forever begin
      @(negedge clk);
      stall_draw = ($random(stall_seed) & 3) != 0;
    end
  end

  // response stall pattern
  always_comb begin
    case (stall_mode)
      0:       resp_rdy = 1'b1;
      1:       resp_rdy = 1'b0;
      default: resp_rdy = stall_draw;
    endcase
  end

  // record requests and check responses at each transfer edge
  always @(posedge clk) begin : check_resp
    logic [imul_pkg::prod_w-1:0] exp_prod;
    if (!reset) begin
      if (req_val && req_rdy) begin
        expect_q.push_back(signed_product(req.a, req.b));
      end
      if (resp_val && resp_rdy) begin
        if (expect_q.size() == 0) begin
          other_count++;
          $display("response arrived with no request pending in %s", test_name);
        end else begin
          exp_prod = expect_q.pop_front();
          if (resp.product !== exp_prod) begin
            mismatch_count++;
            $display("MISMATCH %s expected %h actual %h", test_name, exp_prod, resp.product);
          end
        end
      end
    end
  end

  // called at a falling edge, returns at the falling edge after the transfer
  task automatic send_req(input logic [imul_pkg::op_w-1:0] a, input logic [imul_pkg::op_w-1:0] b);
    int waited;
    req.a   = a;
    req.b   = b;
    req_val = 1'b1;
    waited  = 0;
    // req_rdy only depends on lane state, so it is settled here
    while (!req_rdy && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!req_rdy) begin
      other_count++;
      $display("timed out waiting for request ready in %s", test_name);
    end
    @(negedge clk);
    req_val = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expect_q.size() != 0 && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    if (expect_q.size() != 0) begin
      other_count++;
      $display("timed out in %s with %0d responses missing", test_name, expect_q.size());
    end
  endtask

  initial begin : stimulus
    int   i;
    int   gap;
    logic sent;
    reset    = 1'b1;
    req      = '0;
    req_val  = 1'b0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    // -------------------------------------------------------------------------
    test_name = "sign_corners";
    send_req(32'h0000_0000, 32'h0000_0000);
    send_req(32'h0000_0000, 32'hffff_ffff);
    send_req(32'h0000_0001, 32'h0000_0001);
    send_req(32'hffff_ffff, 32'h0000_0001);
    send_req(32'hffff_ffff, 32'hffff_ffff);
    send_req(32'h8000_0000, 32'h8000_0000);
    send_req(32'h8000_0000, 32'hffff_ffff);
    send_req(32'h7fff_ffff, 32'h8000_0000);
    send_req(32'h7fff_ffff, 32'h7fff_ffff);
    send_req(32'hffff_fffd, 32'h0000_0005);
    send_req(32'h0001_e240, 32'hffff_e57b);
    wait_drain();

    // isolated request, timed by the latency assertions
    test_name = "single_latency";
    send_req(32'h0001_2345, 32'hffff_fc00);
    wait_drain();

    test_name = "back_to_back";
    for (i = 0; i < 8; i++) begin
      send_req($random(seed), $random(seed));
    end
    wait_drain();

    // -------------------------------------------------------------------------
    // keep offering requests while responses are blocked
    test_name  = "back_pressure";
    stall_mode = 1;
    req.a      = $random(seed);
    req.b      = $random(seed);
    req_val    = 1'b1;
    for (i = 0; i < 100; i++) begin
      sent = req_rdy;
      @(negedge clk);
      if (sent) begin
        req.a = $random(seed);
        req.b = $random(seed);
      end
    end
    stall_mode = 0;
    // the pending request still has to complete its transfer
    send_req(req.a, req.b);
    wait_drain();

    test_name  = "random_soak";
    stall_mode = 2;
    for (i = 0; i < 300; i++) begin
      gap = $random(seed) & 3;
      repeat (gap) @(negedge clk);
      send_req($random(seed), $random(seed));
    end
    stall_mode = 0;
    wait_drain();

    $display("errors: %0d mismatches, %0d other, %0d assertion failures",
             mismatch_count, other_count, u_dut.u_assert.fail_count);
    if (mismatch_count + other_count + u_dut.u_assert.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/imul_tb_assert.sv */
// protocol and latency checks, bound into imul_top
// each failure bumps fail_count, which the testbench reads for its summary

`timescale 1ns/10ps
`default_nettype none

module imul_tb_assert (
  input  logic                           clk,
  input  logic                           reset,
  input  imul_pkg::mul_req_t             req,
  input  logic                           req_val,
  input  logic                           req_rdy,
  input  imul_pkg::mul_resp_t            resp,
  input  logic                           resp_val,
  input  logic                           resp_rdy,
  input  logic [imul_pkg::num_lanes-1:0] lane_idle
);

  int fail_count = 0;
  // accepted requests not yet returned
  int outstanding;
  // 1..35 while timing a request that entered an empty multiplier
  int lat_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= 0;
    end else if ((req_val && req_rdy) && !(resp_val && resp_rdy)) begin
      outstanding <= outstanding + 1;
    end else if (!(req_val && req_rdy) && (resp_val && resp_rdy)) begin
      outstanding <= outstanding - 1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lat_cnt <= 0;
    end else if (lat_cnt == 0) begin
      // all lanes idle and nothing in the output stage
      if (req_val && req_rdy && (&lane_idle) && !resp_val) begin
        lat_cnt <= 1;
      end
    end else if (lat_cnt == 35) begin
      lat_cnt <= 0;
    end else begin
      lat_cnt <= lat_cnt + 1;
    end
  end

  // ---------------------------------------------------------------------------

  req_hold: assert property (@(posedge clk) disable iff (reset)
    (req_val && !req_rdy) |=> (req_val && $stable(req)))
    else begin
      fail_count++;
      $error("request dropped or changed while stalled");
    end

  resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp)))
    else begin
      fail_count++;
      $error("response dropped or changed while stalled");
    end

  // four lanes plus the output register
  in_flight_max: assert property (@(posedge clk) disable iff (reset)
    outstanding <= imul_pkg::num_lanes + 1)
    else begin
      fail_count++;
      $error("too many requests outstanding");
    end

  lat_quiet: assert property (@(posedge clk) disable iff (reset)
    ((lat_cnt >= 1) && (lat_cnt <= 34)) |-> !resp_val)
    else begin
      fail_count++;
      $error("response earlier than 34 cycles");
    end

  lat_exact: assert property (@(posedge clk) disable iff (reset)
    (lat_cnt == 35) |-> resp_val)
    else begin
      fail_count++;
      $error("response missing 34 cycles after request");
    end

  reset_state: assert property (@(posedge clk)
    $fell(reset) |-> (!resp_val && req_rdy))
    else begin
      fail_count++;
      $error("wrong handshake state after reset");
    end

endmodule

bind imul_top imul_tb_assert u_assert (
  .clk       (clk),
  .reset     (reset),
  .req       (req),
  .req_val   (req_val),
  .req_rdy   (req_rdy),
  .resp      (resp),
  .resp_val  (resp_val),
  .resp_rdy  (resp_rdy),
  .lane_idle (lane_idle)
);

`default_nettype wire
